// ==== common/cdcPkg.sv ====
`default_nettype none

package cdcPkg;

    localparam int dataWidth = 32;
    localparam int seqWidth = 8;

    localparam int depthLog2 = 4;
    localparam int fifoDepth = 1 << depthLog2;
    localparam int ptrWidth = depthLog2 + 1;  // extra wrap bit tells full from empty

    localparam int syncStages = 3;

    // the write side sees the read pointer late by the synchronizer chain
    // plus the Gray register, so keep some entries free
    localparam int headroom = 2 * syncStages + 2;
    localparam int fillLimit = fifoDepth - headroom;  // ready only below this fill

    localparam int resetPipeStages = 2;  // local read reset delay in the FIFO wrapper

    typedef struct packed {
        logic [dataWidth-1:0] data;  // payload
        logic [seqWidth-1:0] seq;    // sequence tag, wraps
    } beat_t;

endpackage

`default_nettype wire

// ==== logic/resetSynchronizer.sv ====
`timescale 1ns/1ps
`default_nettype none

module resetSynchronizer
    import cdcPkg::*;
(
    input wire clk,
    input wire aresetnIn,   // asynchronous, active low
    output logic resetnOut  // released on a clk edge
);

    logic [syncStages-1:0] resetChain;

    // clears at once, lets a one walk through before release
    always_ff @(posedge clk or negedge aresetnIn) begin
        if (!aresetnIn) begin
            resetChain <= '0;
        end else begin
            resetChain <= {resetChain[syncStages-2:0], 1'b1};
        end
    end

    assign resetnOut = resetChain[syncStages-1];

endmodule

`default_nettype wire

// ==== cdcFifo/grayPointerSync.sv ====
`timescale 1ns/1ps
`default_nettype none

module grayPointerSync
    import cdcPkg::*;
(
    input wire srcClk,
    input wire srcResetn,
    input wire dstClk,
    input wire dstResetn,
    input wire [ptrWidth-1:0] binIn,
    output logic [ptrWidth-1:0] binOut
);

    logic [ptrWidth-1:0] grayReg;
    logic [ptrWidth-1:0] syncChain [syncStages];

    always_ff @(posedge srcClk or negedge srcResetn) begin
        if (!srcResetn) begin
            grayReg <= '0;
        end else begin
            grayReg <= binIn ^ (binIn >> 1);  // only one bit flips per increment
        end
    end

    always_ff @(posedge dstClk or negedge dstResetn) begin
        if (!dstResetn) begin
            for (int i = 0; i < syncStages; i++) begin
                syncChain[i] <= '0;
            end
        end else begin
            syncChain[0] <= grayReg;  // first stage may go metastable
            for (int i = 1; i < syncStages; i++) begin
                syncChain[i] <= syncChain[i-1];
            end
        end
    end

    // back to binary, each bit is the xor of all higher Gray bits
    always_comb begin
        for (int i = 0; i < ptrWidth; i++) begin
            binOut[i] = ^(syncChain[syncStages-1] >> i);
        end
    end

    // a multi-bit jump here would defeat the whole crossing
    assert property (@(posedge srcClk) disable iff (!srcResetn)
        $countones(grayReg ^ $past(grayReg)) <= 1);

endmodule

`default_nettype wire

// ==== cdcFifo/dualClockFifo.sv ====
`timescale 1ns/1ps
`default_nettype none

module dualClockFifo
    import cdcPkg::*;
(
    input wire clk,
    input wire writeResetn,
    input wire writeEnable,
    input wire beat_t dataIn,
    output logic [ptrWidth-1:0] wrUsedWords,

    input wire readClk,
    input wire readResetn,
    input wire readEnable,
    output logic rdEmpty,
    output beat_t dataOut
);

    beat_t memory [fifoDepth];

    logic [ptrWidth-1:0] writePtr;
    logic [ptrWidth-1:0] readPtr;
    logic [ptrWidth-1:0] writePtrSync;  // write pointer seen on readClk
    logic [ptrWidth-1:0] readPtrSync;   // read pointer seen on clk
    logic isReading;

    grayPointerSync writePtrSync_i (
        .srcClk(clk),
        .srcResetn(writeResetn),
        .dstClk(readClk),
        .dstResetn(readResetn),
        .binIn(writePtr),
        .binOut(writePtrSync)
    );

    grayPointerSync readPtrSync_i (
        .srcClk(readClk),
        .srcResetn(readResetn),
        .dstClk(clk),
        .dstResetn(writeResetn),
        .binIn(readPtr),
        .binOut(readPtrSync)
    );

    assign wrUsedWords = writePtr - readPtrSync;  // pessimistic, read side lags
    assign rdEmpty = writePtrSync == readPtr;
    assign isReading = readEnable && !rdEmpty;  // reads on empty are dropped

    always_ff @(posedge clk or negedge writeResetn) begin
        if (!writeResetn) begin
            writePtr <= '0;
        end else if (writeEnable) begin
            writePtr <= writePtr + 1'b1;  // wraps through the extra bit
        end
    end

    always_ff @(posedge clk) begin
        if (writeEnable) begin
            memory[writePtr[depthLog2-1:0]] <= dataIn;
        end
    end

    always_ff @(posedge readClk or negedge readResetn) begin
        if (!readResetn) begin
            readPtr <= '0;
        end else if (isReading) begin
            readPtr <= readPtr + 1'b1;
        end
    end

    always_ff @(posedge readClk) begin
        if (isReading) begin
            dataOut <= memory[readPtr[depthLog2-1:0]];  // one cycle read latency
        end
    end

    // the writer must have paused before the memory fills up
    assert property (@(posedge clk) disable iff (!writeResetn)
        writeEnable |-> wrUsedWords < ptrWidth'(fifoDepth));

endmodule

`default_nettype wire

// ==== cdcFifo/dualClockFifoWithDataValid.sv ====
`timescale 1ns/1ps
`default_nettype none

module dualClockFifoWithDataValid
    import cdcPkg::*;
(
    input wire clk,
    input wire writeResetn,
    input wire writeEnable,
    input wire beat_t dataIn,
    output logic [ptrWidth-1:0] wrUsedWords,

    input wire readClk,
    input wire readResetn,
    input wire readEnable,
    output logic dataOutValid,
    output beat_t dataOut
);

    logic [resetPipeStages-1:0] resetPipe;
    logic readResetnLocal;
    logic rdEmpty;

    // local copy of the read reset, a couple of cycles behind, to keep fanout short
    always_ff @(posedge readClk) begin
        resetPipe <= {resetPipe[resetPipeStages-2:0], readResetn};
    end

    assign readResetnLocal = resetPipe[resetPipeStages-1];

    // one flag per request, lines up with dataOut
    always_ff @(posedge readClk or negedge readResetnLocal) begin
        if (!readResetnLocal) begin
            dataOutValid <= 1'b0;
        end else begin
            dataOutValid <= readEnable && !rdEmpty;
        end
    end

    dualClockFifo fifo_i (
        .clk(clk),
        .writeResetn(writeResetn),
        .writeEnable(writeEnable),
        .dataIn(dataIn),
        .wrUsedWords(wrUsedWords),
        .readClk(readClk),
        .readResetn(readResetnLocal),
        .readEnable(readEnable),
        .rdEmpty(rdEmpty),
        .dataOut(dataOut)
    );

endmodule

`default_nettype wire

// ==== logic/writeThrottle.sv ====
`timescale 1ns/1ps
`default_nettype none

module writeThrottle
    import cdcPkg::*;
(
    input wire clk,
    input wire resetn,

    input wire inValid,
    output logic inReady,
    input wire [dataWidth-1:0] inData,

    input wire [ptrWidth-1:0] wrUsedWords,
    output logic writeEnable,
    output beat_t writeWord
);

    logic [seqWidth-1:0] seqCount;
    logic [ptrWidth:0] fillAfterWrite;

    assign writeEnable = inValid && inReady;  // beat goes straight into the FIFO

    // fill level once this cycle's write has landed
    assign fillAfterWrite = {1'b0, wrUsedWords} + {{ptrWidth{1'b0}}, writeEnable};

    // ready is registered so it stays low through reset
    always_ff @(posedge clk or negedge resetn) begin
        if (!resetn) begin
            inReady <= 1'b0;
        end else begin
            inReady <= fillAfterWrite < fillLimit;
        end
    end

    always_ff @(posedge clk or negedge resetn) begin
        if (!resetn) begin
            seqCount <= '0;
        end else if (writeEnable) begin
            seqCount <= seqCount + 1'b1;  // wraps on purpose
        end
    end

    always_comb begin
        writeWord.data = inData;
        writeWord.seq = seqCount;
    end

endmodule

`default_nettype wire

// ==== logic/readDrain.sv ====
`timescale 1ns/1ps
`default_nettype none

module readDrain
    import cdcPkg::*;
(
    input wire readClk,
    input wire resetn,

    output logic readEnable,
    input wire dataOutValid,
    input wire beat_t readWord,

    output logic outValid,
    input wire outReady,
    output logic [dataWidth-1:0] outData,
    output logic seqError
);

    beat_t slots [2];          // slot 0 is the head
    beat_t slotsNext [2];
    logic [1:0] slotValid;
    logic [1:0] slotValidNext;
    logic [1:0] committed;     // buffered plus the request in flight
    logic takeOut;
    logic [seqWidth-1:0] expectedSeq;

    assign takeOut = outValid && outReady;
    assign outValid = slotValid[0];
    assign outData = slots[0].data;

    always_comb begin
        slotsNext = slots;
        slotValidNext = slotValid;
        if (takeOut) begin
            slotsNext[0] = slots[1];  // shift up
            slotValidNext = {1'b0, slotValid[1]};
        end
        if (dataOutValid) begin
            if (!slotValidNext[0]) begin
                slotsNext[0] = readWord;
                slotValidNext[0] = 1'b1;
            end else begin
                slotsNext[1] = readWord;
                slotValidNext[1] = 1'b1;
            end
        end
    end

    assign committed = {1'b0, slotValidNext[0]} + {1'b0, slotValidNext[1]} + {1'b0, readEnable};

    always_ff @(posedge readClk or negedge resetn) begin
        if (!resetn) begin
            slotValid <= '0;
            readEnable <= 1'b0;
        end else begin
            slotValid <= slotValidNext;
            readEnable <= committed < 2'd2;  // keep room for the answer
        end
    end

    always_ff @(posedge readClk) begin
        slots <= slotsNext;
    end

    // tags must arrive in order, error stays until reset
    always_ff @(posedge readClk or negedge resetn) begin
        if (!resetn) begin
            expectedSeq <= '0;
            seqError <= 1'b0;
        end else if (dataOutValid) begin
            expectedSeq <= expectedSeq + 1'b1;
            if (readWord.seq != expectedSeq) begin
                seqError <= 1'b1;
            end
        end
    end

    // an arriving word always finds a free slot
    assert property (@(posedge readClk) disable iff (!resetn)
        dataOutValid |-> (slotValid != 2'b11) || takeOut);

    assert property (@(posedge readClk) disable iff (!resetn)
        outValid && !outReady |=> outValid && $stable(outData));

endmodule

`default_nettype wire

// ==== logic/cdcBridgeTop.sv ====
`timescale 1ns/1ps
`default_nettype none

module cdcBridgeTop
    import cdcPkg::*;
(
    input wire clk,
    input wire readClk,
    input wire aresetnIn,

    input wire inValid,
    output logic inReady,
    input wire [dataWidth-1:0] inData,

    output logic outValid,
    input wire outReady,
    output logic [dataWidth-1:0] outData,

    output logic seqError
);

    logic writeResetn;
    logic readResetn;
    logic writeEnable;
    beat_t writeWord;
    logic [ptrWidth-1:0] wrUsedWords;
    logic readEnable;
    logic dataOutValid;
    beat_t readWord;

    resetSynchronizer writeReset_i (
        .clk(clk),
        .aresetnIn(aresetnIn),
        .resetnOut(writeResetn)
    );

    resetSynchronizer readReset_i (
        .clk(readClk),
        .aresetnIn(aresetnIn),
        .resetnOut(readResetn)
    );

    writeThrottle throttle_i (
        .clk(clk),
        .resetn(writeResetn),
        .inValid(inValid),
        .inReady(inReady),
        .inData(inData),
        .wrUsedWords(wrUsedWords),
        .writeEnable(writeEnable),
        .writeWord(writeWord)
    );

    dualClockFifoWithDataValid fifo_i (
        .clk(clk),
        .writeResetn(writeResetn),
        .writeEnable(writeEnable),
        .dataIn(writeWord),
        .wrUsedWords(wrUsedWords),
        .readClk(readClk),
        .readResetn(readResetn),
        .readEnable(readEnable),
        .dataOutValid(dataOutValid),
        .dataOut(readWord)
    );

    readDrain drain_i (
        .readClk(readClk),
        .resetn(readResetn),
        .readEnable(readEnable),
        .dataOutValid(dataOutValid),
        .readWord(readWord),
        .outValid(outValid),
        .outReady(outReady),
        .outData(outData),
        .seqError(seqError)
    );

endmodule

`default_nettype wire

// ==== testbench/cdcBridgeTb.sv ====
`timescale 1ns/1ps
`default_nettype none

module cdcBridgeTb
    import cdcPkg::*;
();

    localparam int totalBeats = 400;
    localparam int freeFlowEnd = 100;        // beats taken before back-pressure starts
    localparam int backPressureEnd = 250;    // beats taken before the stall
    localparam int stallCycles = 60;         // readClk cycles with outReady low
    localparam int timeoutCycles = 10 * totalBeats + 400;

    logic clk;
    logic readClk;
    logic aresetnIn;
    logic inValid;
    logic inReady;
    logic [dataWidth-1:0] inData;
    logic outValid;
    logic outReady;
    logic [dataWidth-1:0] outData;
    logic seqError;

    logic [dataWidth-1:0] scoreboard [$];   // accepted words, oldest first
    logic [dataWidth-1:0] expectedWord;
    logic [dataWidth-1:0] heldData;
    logic [31:0] rngState = 32'd19;
    int acceptedCount = 0;
    int takenCount = 0;
    int cycleCount = 0;
    int phase = 0;                          // 1 free flow, 2 random, 3 stall, 4 drain
    bit holdPending = 1'b0;
    bit wasInReset = 1'b1;
    bit stallThrottled = 1'b0;

    cdcBridgeTop dut_i (
        .clk(clk),
        .readClk(readClk),
        .aresetnIn(aresetnIn),
        .inValid(inValid),
        .inReady(inReady),
        .inData(inData),
        .outValid(outValid),
        .outReady(outReady),
        .outData(outData),
        .seqError(seqError)
    );

    function automatic logic [31:0] xorshift(input logic [31:0] state);
        logic [31:0] x;
        x = state;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    task automatic stopFailed();
        $display("TESTBENCH FAILED");
        $fatal(1, "run stopped at the first error");
    endtask

    task automatic reportMismatch(input string testName, input logic [31:0] expectedValue,
                                  input logic [31:0] actualValue);
        $display("FAILED %s: expected %h, actual %h", testName, expectedValue, actualValue);
        stopFailed();
    endtask

    task automatic abortRun(input string reason);
        $display("%s", reason);
        stopFailed();
    endtask

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    initial begin
        readClk = 1'b0;
        forever #35 readClk = ~readClk;
    end

    // write side, checks reset values, throttle and timeout on clk
    always @(posedge clk) begin
        cycleCount++;
        assert (cycleCount < timeoutCycles)
            else abortRun("timeout: the stream did not finish in time");
        if (!aresetnIn || wasInReset) begin
            assert (!inReady && !outValid && !seqError)
                else abortRun("an output was high during reset or just after it");
        end
        wasInReset = !aresetnIn;
        if (phase == 3 && !inReady) begin
            stallThrottled = 1'b1;
        end
    end

    // read side, scoreboard and stability checks
    always @(posedge readClk) begin
        if (holdPending) begin
            assert (outValid) else abortRun("outValid dropped before the word was taken");
            assert (outData == heldData) else reportMismatch("stability", heldData, outData);
        end
        if (outValid && outReady) begin
            assert (scoreboard.size() > 0) else abortRun("an output word came with none expected");
            expectedWord = scoreboard.pop_front();
            assert (outData == expectedWord) else reportMismatch("order", expectedWord, outData);
            takenCount++;
        end
        holdPending = outValid && !outReady;
        heldData = outData;
        if (phase == 3) begin
            assert (acceptedCount - takenCount <= fifoDepth + 2)
                else abortRun("too many beats accepted while the output was stalled");
        end
        assert (!seqError) else abortRun("the sequence tag check flagged an error");
    end

    // input stream, one beat after the other
    initial begin
        wait (aresetnIn);
        @(posedge clk);
        #5;
        for (int n = 0; n < totalBeats; n++) begin
            rngState = xorshift(rngState);
            inValid = 1'b1;
            inData = rngState;
            do begin
                @(posedge clk);
            end while (!inReady);  // beat moves at the edge where ready was high
            scoreboard.push_back(inData);
            acceptedCount++;
            #5;
        end
        inValid = 1'b0;
    end

    // output ready pattern through the four phases
    initial begin
        wait (aresetnIn);
        @(posedge readClk);
        #5;
        phase = 1;
        outReady = 1'b1;
        do begin
            @(posedge readClk);
            #5;
        end while (takenCount < freeFlowEnd);
        phase = 2;
        while (takenCount < backPressureEnd) begin
            rngState = xorshift(rngState);
            outReady = rngState[0];  // high about half the time
            @(posedge readClk);
            #5;
        end
        phase = 3;
        outReady = 1'b0;
        repeat (stallCycles) @(posedge readClk);
        #5;
        assert (stallThrottled) else abortRun("inReady never fell during the output stall");
        phase = 4;
        outReady = 1'b1;
    end

    initial begin
        inValid = 1'b0;
        inData = '0;
        outReady = 1'b0;
        aresetnIn = 1'b1;
        #1 aresetnIn = 1'b0;  // clean falling edge for the asynchronous resets
        repeat (16) @(posedge clk);
        #5 aresetnIn = 1'b1;
        wait (takenCount == totalBeats);
        @(posedge readClk);
        #5;
        assert (!outValid) else abortRun("an extra word appeared after the last one");
        assert (!seqError) else abortRun("the sequence tag check flagged an error");
        $display("TESTBENCH PASSED");
        $finish;
    end

endmodule

`default_nettype wire

// ==== all.f ====
common/cdcPkg.sv
logic/resetSynchronizer.sv
cdcFifo/grayPointerSync.sv
cdcFifo/dualClockFifo.sv
cdcFifo/dualClockFifoWithDataValid.sv
logic/writeThrottle.sv
logic/readDrain.sv
logic/cdcBridgeTop.sv
testbench/cdcBridgeTb.sv

// ==== Makefile ====
# Verilator build and run of the CDC stream bridge testbench

.PHONY: simulate clean

simulate:
	verilator --binary --timing --assert -Wno-fatal --top-module cdcBridgeTb \
		-f all.f -o cdcBridgeSim
	./obj_dir/cdcBridgeSim

clean:
	rm -rf obj_dir
